/* design/feature_pkg.sv */
`default_nettype none

package feature_pkg;

    // data sizes
    localparam int feature_w = 8;
    localparam int bank_lanes = 4;
    localparam int total_lanes = 8;
    localparam int feats_per_word = 4;

    // fifo geometry, depth counted in memory words
    localparam int fifo_depth = 16;
    localparam int almost_full_level = 12;
    localparam int word_aw = $clog2(fifo_depth);
    localparam int feat_aw = $clog2(feats_per_word);
    localparam int fifo_cnt_w = $clog2(fifo_depth * feats_per_word + 1);

    // scan geometry and downstream pipeline delays
    localparam int dim_w = 10;
    localparam int conv_latency = 11;
    localparam int finish_latency = 12;

    typedef logic [feature_w-1:0] feature_t;

    // element 0 sits in the low bits and is read first
    typedef feature_t [feats_per_word-1:0] lane_word_t;
    typedef lane_word_t [bank_lanes-1:0] mem_word_t;
    typedef feature_t [bank_lanes-1:0] bank_vec_t;

    // bank 1 in lanes 0..3, bank 2 in lanes 4..7
    typedef feature_t [total_lanes-1:0] feature_vec_t;

    typedef struct packed {
        logic [dim_w-1:0] row_size;
        logic [dim_w-1:0] col_size;
        logic [2:0]       padding;
        logic [2:0]       kernel_size;
        logic [2:0]       stride;
        logic             double_bank;
    } scan_cfg_t;

    typedef struct packed {
        logic [dim_w-1:0] row;
        logic [dim_w-1:0] col;
        logic             issue;
    } scan_pos_t;

endpackage

`default_nettype wire

/* design/lane_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_fifo (
    input  logic                    system_clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    wr_en,
    input  feature_pkg::lane_word_t wr_data,
    input  logic                    rd_en,
    output feature_pkg::feature_t   rd_data,
    output logic                    empty,
    output logic                    almost_full
);

    feature_pkg::lane_word_t mem [feature_pkg::fifo_depth];

    logic [feature_pkg::word_aw-1:0] wr_ptr;
    // word index in the high bits, feature within the word in the low bits
    logic [feature_pkg::word_aw+feature_pkg::feat_aw-1:0] rd_ptr;
    logic [feature_pkg::fifo_cnt_w-1:0] count;
    logic [feature_pkg::fifo_cnt_w-1:0] count_add;
    logic [feature_pkg::fifo_cnt_w-1:0] count_sub;
    logic full;

    assign empty = (count == '0);

    // a word slot stays occupied until its last feature is read
    assign full = count > feature_pkg::fifo_cnt_w'((feature_pkg::fifo_depth - 1) *
                                                   feature_pkg::feats_per_word);
    assign almost_full = count > feature_pkg::fifo_cnt_w'((feature_pkg::almost_full_level - 1) *
                                                          feature_pkg::feats_per_word);

    assign count_add = wr_en ? feature_pkg::fifo_cnt_w'(feature_pkg::feats_per_word) : '0;
    assign count_sub = rd_en ? feature_pkg::fifo_cnt_w'(1) : '0;

    always_ff @(posedge system_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_add - count_sub;
        end
    end

    // registered output, data one cycle after rd_en
    always_ff @(posedge system_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr[feature_pkg::word_aw+feature_pkg::feat_aw-1 -:
                                  feature_pkg::word_aw]][rd_ptr[feature_pkg::feat_aw-1:0]];
        end
    end

    a_no_overflow: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        wr_en |-> !full
    );

    a_no_underflow: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        rd_en |-> !empty
    );

endmodule

`default_nettype wire

/* design/feature_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module feature_bank (
    input  logic                   system_clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  feature_pkg::mem_word_t wr_data,
    input  logic                   rd_en,
    output feature_pkg::bank_vec_t rd_data,
    output logic                   empty
);

    logic [feature_pkg::bank_lanes-1:0] lane_empty;
    logic [feature_pkg::bank_lanes-1:0] lane_almost_full;
    logic live;
    logic wr_en;

    // ready held low until the first edge after reset
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign wr_ready = live & ~(|lane_almost_full) & ~clear;
    assign wr_en = wr_valid & wr_ready;

    // one lagging lane stalls the whole bank
    assign empty = |lane_empty;

    // each lane takes its own 32-bit slice of the memory word
    for (genvar i = 0; i < feature_pkg::bank_lanes; i++) begin : g_lane
        lane_fifo u_lane_fifo (
            .system_clk  (system_clk),
            .rst_n       (rst_n),
            .clear       (clear),
            .wr_en       (wr_en),
            .wr_data     (wr_data[i]),
            .rd_en       (rd_en),
            .rd_data     (rd_data[i]),
            .empty       (lane_empty[i]),
            .almost_full (lane_almost_full[i])
        );
    end

endmodule

`default_nettype wire

/* design/padding_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module padding_scanner (
    input  logic                      system_clk,
    input  logic                      rst_n,
    input  logic                      compute_begin,
    input  feature_pkg::scan_cfg_t    cfg,
    input  logic                      out_ready,
    input  logic                      bank1_empty,
    input  logic                      bank2_empty,
    output logic                      bank1_rd,
    output logic                      bank2_rd,
    input  feature_pkg::bank_vec_t    bank1_data,
    input  feature_pkg::bank_vec_t    bank2_data,
    output logic                      out_valid,
    output feature_pkg::feature_vec_t out_data,
    output feature_pkg::scan_pos_t    pos,
    output logic                      compute_finish
);

    feature_pkg::scan_cfg_t cfg_q;
    logic [feature_pkg::dim_w-1:0] row_cnt;
    logic [feature_pkg::dim_w-1:0] col_cnt;
    logic [feature_pkg::dim_w-1:0] pad_w;
    logic [feature_pkg::dim_w-1:0] row_end;
    logic [feature_pkg::dim_w-1:0] col_end;
    logic [feature_pkg::dim_w-1:0] row_last;
    logic [feature_pkg::dim_w-1:0] col_last;
    logic active;
    logic border;
    logic fifo_empty;
    logic pad_issue;
    logic rd_issue;
    logic issue;
    logic last_issue;
    logic pad_q;
    logic rd1_q;
    logic rd2_q;
    logic [feature_pkg::finish_latency:0] finish_pipe;

    // row_end/col_end index the first padding row/column after the map
    assign pad_w = feature_pkg::dim_w'(cfg_q.padding);
    assign row_end = cfg_q.row_size + pad_w;
    assign col_end = cfg_q.col_size + pad_w;
    assign row_last = row_end + pad_w - feature_pkg::dim_w'(1);
    assign col_last = col_end + pad_w - feature_pkg::dim_w'(1);

    assign border = (row_cnt < pad_w) | (row_cnt >= row_end) |
                    (col_cnt < pad_w) | (col_cnt >= col_end);
    assign fifo_empty = bank1_empty | (cfg_q.double_bank & bank2_empty);

    assign pad_issue = active & out_ready & border;
    assign rd_issue = active & out_ready & ~border & ~fifo_empty;
    assign issue = pad_issue | rd_issue;
    assign last_issue = issue & (row_cnt == row_last) & (col_cnt == col_last);

    assign bank1_rd = rd_issue;
    assign bank2_rd = rd_issue & cfg_q.double_bank;

    assign pos.row = row_cnt;
    assign pos.col = col_cnt;
    assign pos.issue = issue;

    // row-major walk over the padded map
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
            active <= 1'b0;
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (compute_begin) begin
            cfg_q <= cfg;
            active <= 1'b1;
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (issue) begin
            if (col_cnt == col_last) begin
                col_cnt <= '0;
                if (row_cnt == row_last) begin
                    active <= 1'b0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // fifo is not fall-through, so the beat lags the issue by one cycle
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            pad_q <= 1'b0;
            rd1_q <= 1'b0;
            rd2_q <= 1'b0;
            finish_pipe <= '0;
        end else begin
            pad_q <= pad_issue;
            rd1_q <= rd_issue;
            rd2_q <= bank2_rd;
            finish_pipe <= {finish_pipe[feature_pkg::finish_latency-1:0], last_issue};
        end
    end

    assign out_valid = pad_q | rd1_q;

    // pads and the unused bank 2 half come out as zeros
    assign out_data[feature_pkg::bank_lanes-1:0] = rd1_q ? bank1_data : '0;
    assign out_data[feature_pkg::total_lanes-1:feature_pkg::bank_lanes] =
        rd2_q ? bank2_data : '0;

    assign compute_finish = finish_pipe[feature_pkg::finish_latency];

    // a new scan only starts while the scanner is idle
    a_begin_when_idle: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        compute_begin |-> !active
    );

endmodule

`default_nettype wire

/* design/window_marker.sv */
`timescale 1ns/1ps
`default_nettype none

module window_marker (
    input  logic                   system_clk,
    input  logic                   rst_n,
    input  logic                   compute_begin,
    input  feature_pkg::scan_cfg_t cfg,
    input  feature_pkg::scan_pos_t pos,
    input  logic                   out_valid,
    output logic                   conv_valid
);

    logic [feature_pkg::dim_w-1:0] first_idx;
    logic [feature_pkg::dim_w-1:0] step;
    logic [feature_pkg::dim_w-1:0] col_last;
    logic [feature_pkg::dim_w-1:0] next_row;
    logic [feature_pkg::dim_w-1:0] next_col;
    logic hit;
    logic mark_q;
    logic [feature_pkg::conv_latency-1:0] conv_pipe;

    // position that closes a window in the current row/column
    assign hit = pos.issue & (pos.row == next_row) & (pos.col == next_col);

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            first_idx <= '0;
            step <= '0;
            col_last <= '0;
            next_row <= '0;
            next_col <= '0;
        end else if (compute_begin) begin
            // first full window ends at kernel_size-1
            first_idx <= feature_pkg::dim_w'(cfg.kernel_size) - feature_pkg::dim_w'(1);
            step <= feature_pkg::dim_w'(cfg.stride);
            col_last <= cfg.col_size + feature_pkg::dim_w'({cfg.padding, 1'b0}) -
                        feature_pkg::dim_w'(1);
            next_row <= feature_pkg::dim_w'(cfg.kernel_size) - feature_pkg::dim_w'(1);
            next_col <= feature_pkg::dim_w'(cfg.kernel_size) - feature_pkg::dim_w'(1);
        end else if (pos.issue) begin
            if (pos.col == col_last) begin
                // end of row, column target restarts
                next_col <= first_idx;
                if (pos.row == next_row) begin
                    next_row <= next_row + step;
                end
            end else if (pos.col == next_col) begin
                next_col <= next_col + step;
            end
        end
    end

    // mark_q lines up with the output beat, then the conv pipeline delay
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            mark_q <= 1'b0;
            conv_pipe <= '0;
        end else begin
            mark_q <= hit;
            conv_pipe <= {conv_pipe[feature_pkg::conv_latency-2:0], mark_q & out_valid};
        end
    end

    assign conv_valid = conv_pipe[feature_pkg::conv_latency-1];

    // scanner must turn every issued position into a beat
    a_mark_has_beat: assert property (
        @(posedge system_clk) disable iff (!rst_n)
        mark_q |-> out_valid
    );

endmodule

`default_nettype wire

/* design/feature_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module feature_buffer_top (
    input  logic                      system_clk,
    input  logic                      rst_n,
    input  logic                      load_begin,
    input  logic                      bank1_valid,
    input  logic                      bank2_valid,
    output logic                      bank1_ready,
    output logic                      bank2_ready,
    input  feature_pkg::mem_word_t    feature_data,
    input  logic                      compute_begin,
    input  feature_pkg::scan_cfg_t    cfg,
    input  logic                      out_ready,
    output logic                      out_valid,
    output feature_pkg::feature_vec_t out_data,
    output logic                      conv_valid,
    output logic                      compute_finish
);

    logic bank1_rd;
    logic bank2_rd;
    logic bank1_empty;
    logic bank2_empty;
    feature_pkg::bank_vec_t bank1_data;
    feature_pkg::bank_vec_t bank2_data;
    feature_pkg::scan_pos_t pos;

    // both banks share the memory word, each has its own handshake
    feature_bank u_bank1 (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .clear      (load_begin),
        .wr_valid   (bank1_valid),
        .wr_ready   (bank1_ready),
        .wr_data    (feature_data),
        .rd_en      (bank1_rd),
        .rd_data    (bank1_data),
        .empty      (bank1_empty)
    );

    feature_bank u_bank2 (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .clear      (load_begin),
        .wr_valid   (bank2_valid),
        .wr_ready   (bank2_ready),
        .wr_data    (feature_data),
        .rd_en      (bank2_rd),
        .rd_data    (bank2_data),
        .empty      (bank2_empty)
    );

    padding_scanner u_scanner (
        .system_clk     (system_clk),
        .rst_n          (rst_n),
        .compute_begin  (compute_begin),
        .cfg            (cfg),
        .out_ready      (out_ready),
        .bank1_empty    (bank1_empty),
        .bank2_empty    (bank2_empty),
        .bank1_rd       (bank1_rd),
        .bank2_rd       (bank2_rd),
        .bank1_data     (bank1_data),
        .bank2_data     (bank2_data),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .pos            (pos),
        .compute_finish (compute_finish)
    );

    window_marker u_marker (
        .system_clk    (system_clk),
        .rst_n         (rst_n),
        .compute_begin (compute_begin),
        .cfg           (cfg),
        .pos           (pos),
        .out_valid     (out_valid),
        .conv_valid    (conv_valid)
    );

endmodule

`default_nettype wire

/* testbench/tb_feature_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_feature_buffer;

    // six short tests need a few hundred cycles, so this leaves a wide margin
    localparam int timeout_cycles = 4000;

    logic system_clk;
    logic rst_n;
    logic load_begin;
    logic bank1_valid;
    logic bank2_valid;
    logic bank1_ready;
    logic bank2_ready;
    feature_pkg::mem_word_t feature_data;
    logic compute_begin;
    feature_pkg::scan_cfg_t cfg;
    logic out_ready;
    logic out_valid;
    feature_pkg::feature_vec_t out_data;
    logic conv_valid;
    logic compute_finish;

    // reference model state
    feature_pkg::mem_word_t bank1_words[$];
    feature_pkg::mem_word_t bank2_words[$];
    feature_pkg::feature_vec_t exp_beats[$];
    logic exp_marks[$];
    int conv_due[$];
    logic [31:0] rng_state;
    int cycle;
    int last_beat_cycle;
    logic checking;
    logic beats_done;
    logic finish_seen;

    feature_buffer_top DUT (
        .system_clk     (system_clk),
        .rst_n          (rst_n),
        .load_begin     (load_begin),
        .bank1_valid    (bank1_valid),
        .bank2_valid    (bank2_valid),
        .bank1_ready    (bank1_ready),
        .bank2_ready    (bank2_ready),
        .feature_data   (feature_data),
        .compute_begin  (compute_begin),
        .cfg            (cfg),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .conv_valid     (conv_valid),
        .compute_finish (compute_finish)
    );

    always #10 system_clk = ~system_clk;

    always @(posedge system_clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: tests did not complete within %0d cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_vec(input string name, input feature_pkg::feature_vec_t expected,
                               input feature_pkg::feature_vec_t actual);
        if (actual !== expected) begin
            $display("error: time %0d ns, %s expected %h actual %h", $time, name, expected,
                     actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: time %0d ns, %s expected %b actual %b", $time, name, expected,
                     actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic random_word(output feature_pkg::mem_word_t w);
        logic [31:0] r;
        for (int i = 0; i < feature_pkg::bank_lanes; i++) begin
            next_random(r);
            w[i] = r;
        end
    endtask

    function automatic feature_pkg::scan_cfg_t make_cfg(input int rows, input int cols,
                                                        input int pad, input int k,
                                                        input int s, input logic dbl);
        feature_pkg::scan_cfg_t c;
        c.row_size = feature_pkg::dim_w'(rows);
        c.col_size = feature_pkg::dim_w'(cols);
        c.padding = 3'(pad);
        c.kernel_size = 3'(k);
        c.stride = 3'(s);
        c.double_bank = dbl;
        return c;
    endfunction

    // beat at padded (r, c) closes a k x k window on the stride grid
    function automatic logic is_marked(input int r, input int c, input int k, input int s);
        if (r < k - 1 || c < k - 1) begin
            return 1'b0;
        end
        return ((r - k + 1) % s == 0) && ((c - k + 1) % s == 0);
    endfunction

    // expected beats in row-major order over the padded map
    task automatic build_expected(input feature_pkg::scan_cfg_t sc);
        int p;
        int rd;
        logic border;
        feature_pkg::feature_vec_t v;
        feature_pkg::mem_word_t w1;
        feature_pkg::mem_word_t w2;
        p = int'(sc.padding);
        rd = 0;
        exp_beats.delete();
        exp_marks.delete();
        for (int r = 0; r < int'(sc.row_size) + 2 * p; r++) begin
            for (int c = 0; c < int'(sc.col_size) + 2 * p; c++) begin
                border = (r < p) || (r >= int'(sc.row_size) + p) ||
                         (c < p) || (c >= int'(sc.col_size) + p);
                v = '0;
                if (!border) begin
                    w1 = bank1_words[rd / feature_pkg::feats_per_word];
                    w2 = bank2_words[rd / feature_pkg::feats_per_word];
                    for (int i = 0; i < feature_pkg::bank_lanes; i++) begin
                        v[i] = w1[i][rd % feature_pkg::feats_per_word];
                        if (sc.double_bank) begin
                            v[feature_pkg::bank_lanes + i] =
                                w2[i][rd % feature_pkg::feats_per_word];
                        end
                    end
                    rd++;
                end
                exp_beats.push_back(v);
                exp_marks.push_back(is_marked(r, c, int'(sc.kernel_size), int'(sc.stride)));
            end
        end
    endtask

    task automatic check_outputs();
        feature_pkg::feature_vec_t exp_v;
        logic mark;
        logic exp_conv;
        logic exp_fin;
        if (out_valid) begin
            if (exp_beats.size() == 0) begin
                $display("out_valid high at %0d ns with no beat left in the model", $time);
                stop_with_failure();
            end else begin
                exp_v = exp_beats.pop_front();
                mark = exp_marks.pop_front();
                compare_vec("out_data", exp_v, out_data);
                if (mark) begin
                    conv_due.push_back(cycle + feature_pkg::conv_latency);
                end
                if (exp_beats.size() == 0) begin
                    beats_done = 1'b1;
                    last_beat_cycle = cycle;
                end
            end
        end
        exp_conv = (conv_due.size() > 0) && (conv_due[0] == cycle);
        if (exp_conv) begin
            void'(conv_due.pop_front());
        end
        compare_bit("conv_valid", exp_conv, conv_valid);
        exp_fin = beats_done && (cycle == last_beat_cycle + feature_pkg::finish_latency);
        compare_bit("compute_finish", exp_fin, compute_finish);
        if (compute_finish) begin
            finish_seen = 1'b1;
        end
    endtask

    // outputs sampled mid-cycle, well away from the drive edge
    always @(negedge system_clk) begin
        if (rst_n && checking) begin
            check_outputs();
        end else if (rst_n) begin
            compare_bit("out_valid", 1'b0, out_valid);
            compare_bit("conv_valid", 1'b0, conv_valid);
            compare_bit("compute_finish", 1'b0, compute_finish);
        end
    end

    task automatic clear_banks();
        load_begin = 1'b1;
        @(negedge system_clk);
        compare_bit("bank1_ready", 1'b0, bank1_ready);
        compare_bit("bank2_ready", 1'b0, bank2_ready);
        @(posedge system_clk);
        #2;
        load_begin = 1'b0;
        bank1_words.delete();
        bank2_words.delete();
    endtask

    task automatic load_word(input logic to_bank2, input feature_pkg::mem_word_t w);
        feature_data = w;
        bank1_valid = ~to_bank2;
        bank2_valid = to_bank2;
        @(negedge system_clk);
        while (!(to_bank2 ? bank2_ready : bank1_ready)) begin
            @(negedge system_clk);
        end
        @(posedge system_clk);
        #2;
        bank1_valid = 1'b0;
        bank2_valid = 1'b0;
        if (to_bank2) begin
            bank2_words.push_back(w);
        end else begin
            bank1_words.push_back(w);
        end
    endtask

    task automatic load_random(input logic to_bank2, input int n);
        feature_pkg::mem_word_t w;
        for (int i = 0; i < n; i++) begin
            random_word(w);
            load_word(to_bank2, w);
        end
    endtask

    task automatic run_scan(input feature_pkg::scan_cfg_t sc, input logic random_ready);
        logic [31:0] r;
        build_expected(sc);
        conv_due.delete();
        beats_done = 1'b0;
        finish_seen = 1'b0;
        last_beat_cycle = 0;
        checking = 1'b1;
        cfg = sc;
        compute_begin = 1'b1;
        @(posedge system_clk);
        #2;
        compute_begin = 1'b0;
        while (!finish_seen) begin
            next_random(r);
            out_ready = random_ready ? (r[1:0] != 2'b00) : 1'b1;
            @(posedge system_clk);
            #2;
        end
        out_ready = 1'b1;
        // one more sample catches stray pulses after the finish
        @(posedge system_clk);
        #2;
        checking = 1'b0;
    endtask

    task automatic test_single_plain();
        clear_banks();
        load_random(1'b0, 4);
        run_scan(make_cfg(4, 4, 0, 1, 1, 1'b0), 1'b0);
    endtask

    task automatic test_padding();
        clear_banks();
        load_random(1'b0, 3);
        run_scan(make_cfg(3, 3, 1, 3, 1, 1'b0), 1'b0);
    endtask

    task automatic test_double_bank();
        clear_banks();
        load_random(1'b0, 4);
        load_random(1'b1, 4);
        run_scan(make_cfg(4, 4, 0, 2, 2, 1'b1), 1'b0);
    endtask

    task automatic test_window_stride();
        clear_banks();
        load_random(1'b0, 7);
        run_scan(make_cfg(5, 5, 0, 3, 2, 1'b0), 1'b0);
    endtask

    task automatic test_backpressure();
        clear_banks();
        load_random(1'b0, 4);
        load_random(1'b1, 4);
        run_scan(make_cfg(4, 4, 1, 3, 1, 1'b1), 1'b1);
    endtask

    task automatic test_load_full();
        feature_pkg::mem_word_t w;
        clear_banks();
        bank1_valid = 1'b1;
        for (int n = 0; n < feature_pkg::almost_full_level; n++) begin
            random_word(w);
            feature_data = w;
            @(negedge system_clk);
            compare_bit("bank1_ready", 1'b1, bank1_ready);
            @(posedge system_clk);
            #2;
        end
        // valid stays high, the bank has to hold off
        repeat (3) begin
            @(negedge system_clk);
            compare_bit("bank1_ready", 1'b0, bank1_ready);
            @(posedge system_clk);
            #2;
        end
        bank1_valid = 1'b0;
        clear_banks();
        @(negedge system_clk);
        compare_bit("bank1_ready", 1'b1, bank1_ready);
        @(posedge system_clk);
        #2;
        load_random(1'b0, 4);
        run_scan(make_cfg(4, 4, 0, 1, 1, 1'b0), 1'b0);
    endtask

    initial begin
        system_clk = 1'b0;
        rst_n = 1'b0;
        load_begin = 1'b0;
        bank1_valid = 1'b0;
        bank2_valid = 1'b0;
        feature_data = '0;
        compute_begin = 1'b0;
        cfg = '0;
        out_ready = 1'b1;
        rng_state = 32'h18df0872;
        cycle = 0;
        last_beat_cycle = 0;
        checking = 1'b0;
        beats_done = 1'b0;
        finish_seen = 1'b0;

        repeat (15) @(posedge system_clk);
        @(negedge system_clk);
        compare_bit("out_valid", 1'b0, out_valid);
        compare_bit("conv_valid", 1'b0, conv_valid);
        compare_bit("compute_finish", 1'b0, compute_finish);
        compare_bit("bank1_ready", 1'b0, bank1_ready);
        compare_bit("bank2_ready", 1'b0, bank2_ready);
        @(posedge system_clk);
        #2;
        rst_n = 1'b1;
        @(negedge system_clk);
        compare_bit("bank1_ready", 1'b0, bank1_ready);
        @(posedge system_clk);
        #2;
        // ready comes up one edge after reset release
        @(negedge system_clk);
        compare_bit("bank1_ready", 1'b1, bank1_ready);
        compare_bit("bank2_ready", 1'b1, bank2_ready);
        @(posedge system_clk);
        #2;

        test_single_plain();
        test_padding();
        test_double_bank();
        test_window_stride();
        test_backpressure();
        test_load_full();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* feature_buffer.f */
design/feature_pkg.sv
design/lane_fifo.sv
design/feature_bank.sv
design/padding_scanner.sv
design/window_marker.sv
design/feature_buffer_top.sv
testbench/tb_feature_buffer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_feature_buffer
DUT_TOP   ?= feature_buffer_top
FILELIST  ?= feature_buffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
